/* design/bgpu_pkg.sv */
////////////////////////////////////////
// Shared widths, encodings and structs
// Encoded word is 32 bits, opcode in the
// top byte, stop is 8'hFF
////////////////////////////////////////

package bgpu_pkg;

    localparam int unsigned PcWidth         = 16;
    localparam int unsigned NumWarps        = 4;
    localparam int unsigned WidWidth        = 2;
    localparam int unsigned WarpWidth       = 8;
    localparam int unsigned RegIdxWidth     = 8;
    localparam int unsigned EncInstWidth    = 32;
    localparam int unsigned ImemDepth       = 256;
    localparam int unsigned ImemAddrWidth   = $clog2(ImemDepth);
    localparam int unsigned OperandsPerInst = 2;

    typedef logic [PcWidth-1:0]       pc_t;
    typedef logic [WidWidth-1:0]      wid_t;
    typedef logic [WarpWidth-1:0]     act_mask_t;
    typedef logic [RegIdxWidth-1:0]   reg_idx_t;
    typedef logic [EncInstWidth-1:0]  enc_inst_t;
    typedef logic [ImemAddrWidth-1:0] imem_addr_t;

    // Execution unit, upper two bits of the opcode byte
    typedef enum logic [1:0] {
        EU_IU   = 2'd0,
        EU_LSU  = 2'd1,
        EU_BRU  = 2'd2,
        EU_CTRL = 2'd3
    } eu_e;

    // One code per operation across all units
    typedef enum logic [5:0] {
        IU_ADD    = 6'd0,
        IU_SUB    = 6'd1,
        IU_AND    = 6'd2,
        IU_OR     = 6'd3,
        IU_XOR    = 6'd4,
        IU_SHL    = 6'd5,
        IU_ADDI   = 6'd6,
        IU_SUBI   = 6'd7,
        IU_SHLI   = 6'd8,
        LSU_LOAD  = 6'd9,
        LSU_STORE = 6'd10,
        BRU_BEQZ  = 6'd11,
        BRU_JMP   = 6'd12,
        BRU_SYNC  = 6'd13,
        CTRL_STOP = 6'h3F
    } sub_op_e;

    typedef struct packed {
        eu_e     eu;
        sub_op_e subtype;
    } inst_t;

    typedef struct packed {
        pc_t       pc;
        wid_t      warp_id;
        act_mask_t act_mask;
    } fetch_req_t;

    typedef struct packed {
        fetch_req_t req;
        enc_inst_t  inst;
    } ic_rsp_t;

    // Packet towards the dispatcher
    typedef struct packed {
        pc_t                                pc;
        wid_t                               warp_id;
        act_mask_t                          act_mask;
        inst_t                              inst;
        reg_idx_t                           dst;
        reg_idx_t [OperandsPerInst-1:0]     operands;
        logic     [OperandsPerInst-1:0]     operands_required;
        logic                               branch;
    } dec_out_t;

    // Feedback from decoder to fetcher
    typedef struct packed {
        wid_t warp_id;
        pc_t  next_pc;
        logic control;
        logic stop;
        logic sync;
        logic branch;
    } dec_fb_t;

endpackage : bgpu_pkg

/* design/warp_ctrl_regs.sv */
////////////////////////////////////////
// Warp launch and done status registers
// Config strobe has no back-pressure
// Launch reaches the fetcher 1 cycle late
////////////////////////////////////////

`timescale 1ns/10ps

module warp_ctrl_regs (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           cfg_launch_i,
    input  bgpu_pkg::wid_t                 cfg_warp_i,
    input  bgpu_pkg::pc_t                  cfg_start_pc_i,
    input  bgpu_pkg::act_mask_t            cfg_mask_i,
    input  logic                           stop_i,
    input  bgpu_pkg::wid_t                 stop_warp_i,
    output logic                           launch_o,
    output bgpu_pkg::wid_t                 launch_warp_o,
    output bgpu_pkg::pc_t                  launch_pc_o,
    output bgpu_pkg::act_mask_t            launch_mask_o,
    output logic [bgpu_pkg::NumWarps-1:0]  warp_done_o
);
    import bgpu_pkg::*;

    pc_t                 start_pc_q [NumWarps];
    act_mask_t           mask_q     [NumWarps];
    wid_t                launch_warp_q;
    logic                launch_q;
    logic [NumWarps-1:0] done_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            launch_q <= 1'b0;
            done_q   <= '0;
        end else begin
            launch_q <= cfg_launch_i;
            if (stop_i) begin
                done_q[stop_warp_i] <= 1'b1;
            end
            // A relaunch clears the sticky done bit
            if (cfg_launch_i) begin
                done_q[cfg_warp_i] <= 1'b0;
            end
        end
    end

    // Per-warp start PC and mask
    always_ff @(posedge clk_i) begin
        if (cfg_launch_i) begin
            start_pc_q[cfg_warp_i] <= cfg_start_pc_i;
            mask_q[cfg_warp_i]     <= cfg_mask_i;
            launch_warp_q          <= cfg_warp_i;
        end
    end

    assign launch_o      = launch_q;
    assign launch_warp_o = launch_warp_q;
    assign launch_pc_o   = start_pc_q[launch_warp_q];
    assign launch_mask_o = mask_q[launch_warp_q];
    assign warp_done_o   = done_q;

endmodule : warp_ctrl_regs

/* design/fetcher.sv */
////////////////////////////////////////
// Per-warp PC table and warp scheduler
// One instruction in flight per warp
// Sync releases once all running warps wait
////////////////////////////////////////

`timescale 1ns/10ps

module fetcher (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  launch_i,
    input  bgpu_pkg::wid_t        launch_warp_i,
    input  bgpu_pkg::pc_t         launch_pc_i,
    input  bgpu_pkg::act_mask_t   launch_mask_i,
    output logic                  fetch_valid_o,
    input  logic                  fetch_ready_i,
    output bgpu_pkg::fetch_req_t  fetch_o,
    input  logic                  decoded_i,
    input  bgpu_pkg::dec_fb_t     fb_i,
    output logic                  stop_o,
    output bgpu_pkg::wid_t        stop_warp_o
);
    import bgpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READY,
        WAIT_DEC,
        WAIT_SYNC
    } warp_state_e;

    warp_state_e state_q [NumWarps];
    pc_t         pc_q    [NumWarps];
    act_mask_t   mask_q  [NumWarps];
    wid_t        rr_ptr_q;
    logic        fetch_valid_q;
    fetch_req_t  fetch_q;

    logic pick_found;
    wid_t pick_wid;
    logic load;
    logic any_active;
    logic any_sync;
    logic sync_release;

    // Round-robin search starting at the pointer
    always_comb begin : pick
        wid_t idx;
        pick_found = 1'b0;
        pick_wid   = '0;
        for (int i = 0; i < NumWarps; i++) begin
            idx = rr_ptr_q + wid_t'(i);
            if (!pick_found && (state_q[idx] == READY)) begin
                pick_found = 1'b1;
                pick_wid   = idx;
            end
        end
    end

    always_comb begin : barrier
        any_active = 1'b0;
        any_sync   = 1'b0;
        for (int i = 0; i < NumWarps; i++) begin
            if (state_q[i] inside {READY, WAIT_DEC}) any_active = 1'b1;
            if (state_q[i] == WAIT_SYNC)             any_sync   = 1'b1;
        end
    end

    assign sync_release = any_sync && !any_active;

    // Fetch register refills when empty or when its request is taken
    assign load = pick_found && (!fetch_valid_q || fetch_ready_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NumWarps; i++) state_q[i] <= IDLE;
            rr_ptr_q      <= '0;
            fetch_valid_q <= 1'b0;
        end else begin
            if (sync_release) begin
                for (int i = 0; i < NumWarps; i++) begin
                    if (state_q[i] == WAIT_SYNC) state_q[i] <= READY;
                end
            end
            if (decoded_i) begin
                state_q[fb_i.warp_id] <= fb_i.stop ? IDLE : (fb_i.sync ? WAIT_SYNC : READY);
            end
            if (launch_i) state_q[launch_warp_i] <= READY;

            if (load) begin
                state_q[pick_wid] <= WAIT_DEC;
                rr_ptr_q          <= pick_wid + wid_t'(1);
                fetch_valid_q     <= 1'b1;
            end else if (fetch_ready_i) begin
                fetch_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (decoded_i) pc_q[fb_i.warp_id] <= fb_i.next_pc;
        if (launch_i) begin
            pc_q[launch_warp_i]   <= launch_pc_i;
            mask_q[launch_warp_i] <= launch_mask_i;
        end
        if (load) begin
            fetch_q.pc       <= pc_q[pick_wid];
            fetch_q.warp_id  <= pick_wid;
            fetch_q.act_mask <= mask_q[pick_wid];
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_o       = fetch_q;
    assign stop_o        = decoded_i && fb_i.stop;
    assign stop_warp_o   = fb_i.warp_id;

endmodule : fetcher

/* design/inst_mem.sv */
////////////////////////////////////////
// Instruction memory, 256 words
// Read addressed by the low 8 PC bits
////////////////////////////////////////

`timescale 1ns/10ps

module inst_mem (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  prog_we_i,
    input  bgpu_pkg::imem_addr_t  prog_addr_i,
    input  bgpu_pkg::enc_inst_t   prog_data_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  bgpu_pkg::fetch_req_t  req_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output bgpu_pkg::ic_rsp_t     rsp_o
);
    import bgpu_pkg::*;

    enc_inst_t mem_q [ImemDepth];
    ic_rsp_t   rsp_q;
    logic      rsp_valid_q;
    logic      req_fire;

    // Output register holds its word until consumed
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (prog_we_i) mem_q[prog_addr_i] <= prog_data_i;
        if (req_fire) begin
            rsp_q.req  <= req_i;
            rsp_q.inst <= mem_q[req_i.pc[ImemAddrWidth-1:0]];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule : inst_mem

/* design/decoder.sv */
////////////////////////////////////////
// Combinational instruction decoder
// Stop, jump and sync stay local, only the
// rest goes to the dispatcher
////////////////////////////////////////

`timescale 1ns/10ps

module decoder (
    input  logic                rsp_valid_i,
    input  bgpu_pkg::ic_rsp_t   rsp_i,
    output logic                rsp_ready_o,
    output logic                dec_valid_o,
    input  logic                disp_ready_i,
    output bgpu_pkg::dec_out_t  dec_o,
    output logic                decoded_o,
    output bgpu_pkg::dec_fb_t   fb_o
);
    import bgpu_pkg::*;

    inst_t       inst;
    logic        is_control;
    logic [15:0] jmp_offset;

    assign inst       = inst_t'(rsp_i.inst[31:24]);
    assign jmp_offset = rsp_i.inst[15:0];

    assign rsp_ready_o = disp_ready_i;
    assign dec_valid_o = rsp_valid_i && !is_control;

    // Every instruction leaves on the memory handshake, control ones included
    assign decoded_o = rsp_valid_i && disp_ready_i;

    always_comb begin : decode
        dec_o.pc                = rsp_i.req.pc;
        dec_o.warp_id           = rsp_i.req.warp_id;
        dec_o.act_mask          = rsp_i.req.act_mask;
        dec_o.inst              = inst;
        dec_o.dst               = rsp_i.inst[23:16];
        dec_o.operands[0]       = rsp_i.inst[15:8];
        dec_o.operands[1]       = rsp_i.inst[7:0];
        // Immediates unless the unit says otherwise
        dec_o.operands_required = '0;
        dec_o.branch            = 1'b0;

        fb_o.warp_id = rsp_i.req.warp_id;
        fb_o.next_pc = rsp_i.req.pc + pc_t'(1);
        fb_o.stop    = (inst.eu == EU_CTRL) && (inst.subtype == CTRL_STOP);
        fb_o.sync    = 1'b0;
        fb_o.branch  = 1'b0;
        is_control   = fb_o.stop;

        case (inst.eu)
            EU_IU: begin
                if (inst.subtype inside {IU_ADD, IU_SUB, IU_AND, IU_OR, IU_XOR, IU_SHL}) begin
                    dec_o.operands_required = 2'b11;
                end
                // Operand 0 carries the immediate
                if (inst.subtype inside {IU_ADDI, IU_SUBI, IU_SHLI}) begin
                    dec_o.operands_required = 2'b10;
                end
            end
            EU_LSU: begin
                // Address in operand 0, store data in operand 1
                dec_o.operands_required = 2'b11;
            end
            EU_BRU: begin
                if (inst.subtype == BRU_JMP) begin
                    // Signed 16-bit offset relative to PC plus one
                    fb_o.next_pc = rsp_i.req.pc + pc_t'($signed(jmp_offset)) + pc_t'(1);
                    is_control   = 1'b1;
                end else if (inst.subtype == BRU_SYNC) begin
                    is_control = 1'b1;
                    fb_o.sync  = 1'b1;
                end else begin
                    // Offset immediate in operand 0, condition register in operand 1
                    dec_o.operands_required = 2'b10;
                    dec_o.branch            = 1'b1;
                    fb_o.branch             = 1'b1;
                end
            end
            default: begin
            end
        endcase

        fb_o.control = is_control;
    end

endmodule : decoder

/* design/frontend_top.sv */
////////////////////////////////////////
// Compute unit instruction front end
// Fetch to dispatch in 1 cycle when the
// dispatcher is ready
////////////////////////////////////////

`timescale 1ns/10ps

module frontend_top (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           cfg_launch_i,
    input  bgpu_pkg::wid_t                 cfg_warp_i,
    input  bgpu_pkg::pc_t                  cfg_start_pc_i,
    input  bgpu_pkg::act_mask_t            cfg_mask_i,
    input  logic                           prog_we_i,
    input  bgpu_pkg::imem_addr_t           prog_addr_i,
    input  bgpu_pkg::enc_inst_t            prog_data_i,
    output logic                           dec_valid_o,
    input  logic                           disp_ready_i,
    output bgpu_pkg::dec_out_t             dec_o,
    output logic [bgpu_pkg::NumWarps-1:0]  warp_done_o
);
    import bgpu_pkg::*;

    logic       launch;
    wid_t       launch_warp;
    pc_t        launch_pc;
    act_mask_t  launch_mask;
    logic       stop;
    wid_t       stop_warp;
    logic       fetch_valid;
    logic       fetch_ready;
    fetch_req_t fetch_req;
    logic       ic_valid;
    logic       ic_ready;
    ic_rsp_t    ic_rsp;
    logic       decoded;
    dec_fb_t    dec_fb;

    warp_ctrl_regs u_warp_ctrl_regs (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .cfg_launch_i   (cfg_launch_i),
        .cfg_warp_i     (cfg_warp_i),
        .cfg_start_pc_i (cfg_start_pc_i),
        .cfg_mask_i     (cfg_mask_i),
        .stop_i         (stop),
        .stop_warp_i    (stop_warp),
        .launch_o       (launch),
        .launch_warp_o  (launch_warp),
        .launch_pc_o    (launch_pc),
        .launch_mask_o  (launch_mask),
        .warp_done_o    (warp_done_o)
    );

    fetcher u_fetcher (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .launch_i      (launch),
        .launch_warp_i (launch_warp),
        .launch_pc_i   (launch_pc),
        .launch_mask_i (launch_mask),
        .fetch_valid_o (fetch_valid),
        .fetch_ready_i (fetch_ready),
        .fetch_o       (fetch_req),
        .decoded_i     (decoded),
        .fb_i          (dec_fb),
        .stop_o        (stop),
        .stop_warp_o   (stop_warp)
    );

    inst_mem u_inst_mem (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .req_valid_i (fetch_valid),
        .req_ready_o (fetch_ready),
        .req_i       (fetch_req),
        .rsp_valid_o (ic_valid),
        .rsp_ready_i (ic_ready),
        .rsp_o       (ic_rsp)
    );

    decoder u_decoder (
        .rsp_valid_i  (ic_valid),
        .rsp_i        (ic_rsp),
        .rsp_ready_o  (ic_ready),
        .dec_valid_o  (dec_valid_o),
        .disp_ready_i (disp_ready_i),
        .dec_o        (dec_o),
        .decoded_o    (decoded),
        .fb_o         (dec_fb)
    );

endmodule : frontend_top

/* testbench/tb_clk_gen.sv */
////////////////////////////////////////
// Testbench clock and reset, 8 ns period
// Reset low for the first 5 rising edges
////////////////////////////////////////

`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

/* testbench/tb_frontend.sv */
////////////////////////////////////////
// Table-driven front end testbench
// All warps launch on back-to-back cycles
// Packet order is checked per warp only
////////////////////////////////////////

`timescale 1ns/10ps

module tb_frontend;
    import bgpu_pkg::*;

    typedef struct packed {
        imem_addr_t addr;
        enc_inst_t  word;
    } prog_entry_t;

    typedef struct packed {
        wid_t      warp;
        pc_t       pc;
        act_mask_t mask;
    } launch_entry_t;

    localparam int          NumProg       = 27;
    localparam int          NumLaunch     = 4;
    localparam int          MaxExp        = 32;
    localparam int          TimeoutCycles = 40 * NumProg + 200;
    localparam logic [31:0] Seed          = 32'h5ed2_2962;

    // Top byte is {unit, subtype}, then dst, operand 0, operand 1
    localparam prog_entry_t ProgTable [NumProg] = '{
        // Warp 0 syncs and then jumps forward over two words
        '{8'h00, 32'h0001_0203}, '{8'h01, 32'h4904_0506}, '{8'h02, 32'h8D00_0000},
        '{8'h03, 32'h0607_1008}, '{8'h04, 32'h8C00_0002}, '{8'h05, 32'h00AA_AAAA},
        '{8'h06, 32'h01BB_BBBB}, '{8'h07, 32'h8B00_0509}, '{8'h08, 32'hFF00_0000},
        // Warp 1
        '{8'h10, 32'h0111_1213}, '{8'h11, 32'h0414_1516}, '{8'h12, 32'h8D00_0000},
        '{8'h13, 32'h4A00_1718}, '{8'h14, 32'hFF00_0000},
        // Warp 2 jumps forward before the sync and backward after it
        '{8'h20, 32'h0321_2223}, '{8'h21, 32'h8C00_0003}, '{8'h22, 32'h0524_2526},
        '{8'h23, 32'hFF00_0000}, '{8'h24, 32'h00EE_EEEE}, '{8'h25, 32'h0227_2829},
        '{8'h26, 32'h8D00_0000}, '{8'h27, 32'h072A_012B}, '{8'h28, 32'h8C00_FFF9},
        // Warp 3 has no sync and holds the barrier until it stops
        '{8'h30, 32'h0831_0432}, '{8'h31, 32'h4933_3435}, '{8'h32, 32'h0236_3738},
        '{8'h33, 32'hFF00_0000}
    };

    localparam launch_entry_t LaunchTable [NumLaunch] = '{
        '{2'd0, 16'h0000, 8'hFF},
        '{2'd1, 16'h0010, 8'h0F},
        '{2'd2, 16'h0020, 8'hA5},
        '{2'd3, 16'h0030, 8'h3C}
    };

    logic                clk;
    logic                arst_n;
    logic                cfg_launch_i;
    wid_t                cfg_warp_i;
    pc_t                 cfg_start_pc_i;
    act_mask_t           cfg_mask_i;
    logic                prog_we_i;
    imem_addr_t          prog_addr_i;
    enc_inst_t           prog_data_i;
    logic                dec_valid_o;
    logic                disp_ready_i;
    dec_out_t            dec_o;
    logic [NumWarps-1:0] warp_done_o;

    enc_inst_t           ref_mem   [ImemDepth];
    dec_out_t            exp_mem   [NumWarps][MaxExp];
    int                  exp_phase [NumWarps][MaxExp];
    int                  exp_cnt   [NumWarps];
    int                  disp_cnt  [NumWarps];
    logic [NumWarps-1:0] launched;
    logic                launch_started;
    logic                held;
    dec_out_t            held_pkt;
    int                  mismatch_cnt;
    int                  other_cnt;

    tb_clk_gen u_tb_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    frontend_top u_frontend_top (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .cfg_launch_i   (cfg_launch_i),
        .cfg_warp_i     (cfg_warp_i),
        .cfg_start_pc_i (cfg_start_pc_i),
        .cfg_mask_i     (cfg_mask_i),
        .prog_we_i      (prog_we_i),
        .prog_addr_i    (prog_addr_i),
        .prog_data_i    (prog_data_i),
        .dec_valid_o    (dec_valid_o),
        .disp_ready_i   (disp_ready_i),
        .dec_o          (dec_o),
        .warp_done_o    (warp_done_o)
    );

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        assert (got === expected) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
            mismatch_cnt++;
        end
    endtask

    // Register operands per unit with bit 1 for operand 1
    function automatic logic [1:0] required_operands(input inst_t op);
        logic [1:0] req;
        req = 2'b00;
        if (op.eu == EU_IU && op.subtype inside {IU_ADD, IU_SUB, IU_AND, IU_OR, IU_XOR, IU_SHL})
            req = 2'b11;
        if (op.eu == EU_IU && op.subtype inside {IU_ADDI, IU_SUBI, IU_SHLI})
            req = 2'b10;
        if (op.eu == EU_LSU)
            req = 2'b11;
        if (op.eu == EU_BRU && op.subtype == BRU_BEQZ)
            req = 2'b10;
        return req;
    endfunction

    // Walks one warp's program and tags each packet with its sync count
    task automatic build_expected(input int w, input pc_t start_pc, input act_mask_t mask);
        pc_t       pc;
        enc_inst_t word;
        inst_t     op;
        dec_out_t  pkt;
        int        phase;
        int        steps;
        logic      done;
        pc         = start_pc;
        phase      = 0;
        steps      = 0;
        done       = 1'b0;
        exp_cnt[w] = 0;
        while (!done) begin
            word = ref_mem[pc[ImemAddrWidth-1:0]];
            op   = inst_t'(word[31:24]);
            steps++;
            if (steps > ImemDepth || exp_cnt[w] >= MaxExp) begin
                $display("Reference walk of warp %0d did not reach a stop", w);
                other_cnt++;
                done = 1'b1;
            end else if (op.eu == EU_CTRL && op.subtype == CTRL_STOP) begin
                done = 1'b1;
            end else if (op.eu == EU_BRU && op.subtype == BRU_JMP) begin
                // 16-bit wrap makes the offset signed
                pc = pc + 16'd1 + word[15:0];
            end else if (op.eu == EU_BRU && op.subtype == BRU_SYNC) begin
                phase++;
                pc = pc + 16'd1;
            end else begin
                pkt.pc                = pc;
                pkt.warp_id           = wid_t'(w);
                pkt.act_mask          = mask;
                pkt.inst              = op;
                pkt.dst               = word[23:16];
                pkt.operands[0]       = word[15:8];
                pkt.operands[1]       = word[7:0];
                pkt.operands_required = required_operands(op);
                pkt.branch            = (op.eu == EU_BRU) && (op.subtype == BRU_BEQZ);
                exp_mem[w][exp_cnt[w]]   = pkt;
                exp_phase[w][exp_cnt[w]] = phase;
                exp_cnt[w]++;
                pc = pc + 16'd1;
            end
        end
    endtask

    task automatic check_dispatch(input dec_out_t pkt);
        int       w;
        int       idx;
        int       need;
        dec_out_t ref_pkt;
        w = int'(pkt.warp_id);
        assert (!(pkt.inst.eu == EU_CTRL ||
                  (pkt.inst.eu == EU_BRU && pkt.inst.subtype inside {BRU_JMP, BRU_SYNC})))
        else begin
            $display("Control word at PC 0x%0h of warp %0d reached the dispatcher", pkt.pc, w);
            other_cnt++;
        end
        assert (launched[w] && disp_cnt[w] < exp_cnt[w]) else begin
            $display("Unexpected extra packet from warp %0d at PC 0x%0h", w, pkt.pc);
            other_cnt++;
        end
        if (launched[w] && disp_cnt[w] < exp_cnt[w]) begin
            idx     = disp_cnt[w];
            ref_pkt = exp_mem[w][idx];
            compare_value("dec_o.pc", 64'(pkt.pc), 64'(ref_pkt.pc));
            compare_value("dec_o.act_mask", 64'(pkt.act_mask), 64'(ref_pkt.act_mask));
            compare_value("dec_o.inst", 64'(pkt.inst), 64'(ref_pkt.inst));
            compare_value("dec_o.dst", 64'(pkt.dst), 64'(ref_pkt.dst));
            compare_value("dec_o.operands", 64'(pkt.operands), 64'(ref_pkt.operands));
            compare_value("dec_o.operands_required", 64'(pkt.operands_required),
                          64'(ref_pkt.operands_required));
            compare_value("dec_o.branch", 64'(pkt.branch), 64'(ref_pkt.branch));
            // Every other warp must be done with all earlier sync phases
            for (int v = 0; v < NumWarps; v++) begin
                if (launched[v] && v != w) begin
                    need = 0;
                    for (int k = 0; k < exp_cnt[v]; k++) begin
                        if (exp_phase[v][k] < exp_phase[w][idx]) need++;
                    end
                    assert (disp_cnt[v] >= need) else begin
                        $display("Warp %0d went past sync %0d before warp %0d reached it",
                                 w, exp_phase[w][idx], v);
                        other_cnt++;
                    end
                end
            end
            disp_cnt[w]++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Outputs are sampled mid-cycle while inputs change 1 ns after the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (!launch_started) begin
                compare_value("dec_valid_o", 64'(dec_valid_o), 64'(0));
                compare_value("warp_done_o", 64'(warp_done_o), 64'(0));
            end
            if (held) begin
                compare_value("dec_valid_o (held)", 64'(dec_valid_o), 64'(1));
                compare_value("dec_o (held)", 64'(dec_o), 64'(held_pkt));
            end
            if (dec_valid_o && disp_ready_i) check_dispatch(dec_o);
            held     = dec_valid_o && !disp_ready_i;
            held_pkt = dec_o;
        end
    end

    // Dispatcher ready is low about one cycle in four
    initial begin
        disp_ready_i = 1'b0;
        void'($urandom(Seed));
        wait (arst_n);
        forever begin
            @(posedge clk);
            #1 disp_ready_i = ($urandom % 4) != 0;
        end
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        other_cnt++;
        finish_run();
    end

    initial begin
        cfg_launch_i   = 1'b0;
        cfg_warp_i     = '0;
        cfg_start_pc_i = '0;
        cfg_mask_i     = '0;
        prog_we_i      = 1'b0;
        prog_addr_i    = '0;
        prog_data_i    = '0;
        launched       = '0;
        launch_started = 1'b0;
        held           = 1'b0;
        mismatch_cnt   = 0;
        other_cnt      = 0;
        for (int w = 0; w < NumWarps; w++) begin
            exp_cnt[w]  = 0;
            disp_cnt[w] = 0;
        end
        // Unwritten words read as stop so a stray walk ends
        for (int a = 0; a < ImemDepth; a++) ref_mem[a] = {8'hFF, 16'h0000, 8'(a)};

        wait (arst_n);
        @(posedge clk);
        for (int i = 0; i < NumProg; i++) begin
            #1;
            prog_we_i   = 1'b1;
            prog_addr_i = ProgTable[i].addr;
            prog_data_i = ProgTable[i].word;
            ref_mem[ProgTable[i].addr] = ProgTable[i].word;
            @(posedge clk);
        end
        #1 prog_we_i = 1'b0;
        repeat (4) @(posedge clk);

        for (int i = 0; i < NumLaunch; i++) begin
            build_expected(int'(LaunchTable[i].warp), LaunchTable[i].pc, LaunchTable[i].mask);
        end
        for (int i = 0; i < NumLaunch; i++) begin
            #1;
            cfg_launch_i   = 1'b1;
            cfg_warp_i     = LaunchTable[i].warp;
            cfg_start_pc_i = LaunchTable[i].pc;
            cfg_mask_i     = LaunchTable[i].mask;
            launch_started = 1'b1;
            launched[LaunchTable[i].warp] = 1'b1;
            @(posedge clk);
        end
        #1 cfg_launch_i = 1'b0;

        while ((warp_done_o & launched) != launched) @(posedge clk);
        repeat (10) @(negedge clk);

        compare_value("warp_done_o", 64'(warp_done_o), 64'(launched));
        compare_value("dec_valid_o", 64'(dec_valid_o), 64'(0));
        for (int w = 0; w < NumWarps; w++) begin
            compare_value($sformatf("dispatch count of warp %0d", w),
                          64'(disp_cnt[w]), 64'(exp_cnt[w]));
        end
        finish_run();
    end

endmodule : tb_frontend

/* src.f */
design/bgpu_pkg.sv
design/warp_ctrl_regs.sv
design/fetcher.sv
design/inst_mem.sv
design/decoder.sv
design/frontend_top.sv
testbench/tb_clk_gen.sv
testbench/tb_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert --top-module tb_frontend -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
exit 0
